// File: hdl/query_pkg.sv
package query_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int NUM_PRED  = 8;      // predicates, also columns per record
	localparam int COL_W     = 32;
	localparam int BEAT_W    = 256;
	localparam int NUM_BEATS = 4;      // parameter beats per command
	localparam int SEL_W     = $clog2(NUM_PRED);
	localparam int PRED_W    = 48;     // one predicate slot in a beat
	localparam int TABLE_W   = 2 ** NUM_PRED;
	localparam int CNT_W     = 32;     // record count field

	// predicates per beat
	localparam int PREDS_LO  = 5;
	localparam int PREDS_HI  = NUM_PRED - PREDS_LO;

	////////////////////////////////////////
	// opcodes and states
	////////////////////////////////////////

	// comparison codes, anything else compares false
	typedef enum logic [7:0]
	{
		op_eq = 8'd0,
		op_ne = 8'd1,
		op_lt = 8'd2,
		op_gt = 8'd3,
		op_le = 8'd4,
		op_ge = 8'd5
	} pred_op_e;

	typedef enum logic [2:0]
	{
		st_idle,
		st_header,    // beat 0, record count
		st_table,     // beat 1, truth table
		st_pred_lo,   // beat 2, predicates 0..4
		st_pred_hi,   // beat 3, predicates 5..7
		st_active
	} ctrl_state_e;

	////////////////////////////////////////
	// beat and record layouts
	////////////////////////////////////////

	typedef struct packed
	{
		logic [COL_W-1:0] value;
		logic [7:0]       col;
		pred_op_e         op;   // low byte of the slot
	} pred_t;

	typedef pred_t [NUM_PRED-1:0] pred_set_t;

	// column 0 in the low bits
	typedef logic [NUM_PRED-1:0][COL_W-1:0] record_t;

	// bit n is the result for predicate vector n
	typedef logic [TABLE_W-1:0] truth_table_t;

endpackage

// File: hdl/predicate_unit.sv
`timescale 1ns/1ps

module predicate_unit
	import query_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  pred_t   pred,
	input  logic    in_valid,
	input  record_t rec,
	output logic    hit,
	output logic    out_valid
);

	logic [COL_W-1:0] col_val;
	logic             col_ok;
	logic             cmp;

	////////////////////////////////////////
	// column select
	////////////////////////////////////////

	// out of range column never hits
	assign col_ok  = (pred.col < 8'(NUM_PRED));
	assign col_val = rec[pred.col[SEL_W-1:0]];

	////////////////////////////////////////
	// compare, unsigned
	////////////////////////////////////////

	always_comb
	begin
		case (pred.op)
			op_eq:
				cmp = (col_val == pred.value);
			op_ne:
				cmp = (col_val != pred.value);
			op_lt:
				cmp = (col_val < pred.value);
			op_gt:
				cmp = (col_val > pred.value);
			op_le:
				cmp = (col_val <= pred.value);
			op_ge:
				cmp = (col_val >= pred.value);
			default:
				cmp = 1'b0;   // undefined opcode
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
			hit <= col_ok && cmp;
	end

endmodule

// File: hdl/match_lookup.sv
`timescale 1ns/1ps

module match_lookup
	import query_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [NUM_PRED-1:0] hits,
	input  truth_table_t        table_bits,
	input  logic [CNT_W-1:0]    record_count,
	output logic                match_valid,
	output logic                match,
	output logic                query_done
);

	logic [CNT_W-1:0] seen;   // records already looked up
	logic             last;

	////////////////////////////////////////
	// end of query detect
	////////////////////////////////////////

	assign last = ((seen + CNT_W'(1)) == record_count);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			seen        <= '0;
			match_valid <= 1'b0;
			query_done  <= 1'b0;
		end
		else
		begin
			match_valid <= in_valid;
			query_done  <= in_valid && last;
			if (in_valid)
			begin
				if (last)
					seen <= '0;   // ready for the next command
				else
					seen <= seen + CNT_W'(1);
			end
		end
	end

	////////////////////////////////////////
	// truth table read
	////////////////////////////////////////

	// predicate bits form the address
	always_ff @(posedge clk)
	begin
		if (in_valid)
			match <= table_bits[hits];
	end

endmodule

// File: hdl/query_controller.sv
`timescale 1ns/1ps

module query_controller
	import query_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_pending,
	input  logic [BEAT_W-1:0]    para_data,
	input  logic                 rec_valid,
	input  record_t              rec_data,
	input  logic                 query_done,
	output logic                 para_rd,
	output logic                 cmd_ack,
	output logic                 query_active,
	output pred_set_t            preds,
	output truth_table_t         table_bits,
	output logic [CNT_W-1:0]     record_count,
	output logic                 stage_valid,
	output record_t              stage_rec
);

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic        loading;
	logic        accept;

	////////////////////////////////////////
	// command FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
			begin
				if (cmd_pending)
					next_state = st_header;
			end
			st_header:
				next_state = st_table;
			st_table:
				next_state = st_pred_lo;
			st_pred_lo:
				next_state = st_pred_hi;
			st_pred_hi:
				next_state = st_active;
			st_active:
			begin
				// last match leaves the pipe
				if (query_done)
					next_state = st_idle;
			end
			default:
				next_state = st_idle;
		endcase
	end

	// one beat popped per load state
	assign loading = (state == st_header) || (state == st_table) ||
		(state == st_pred_lo) || (state == st_pred_hi);
	assign para_rd = loading;

	// pop the command once all beats are in
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cmd_ack <= 1'b0;
		else
			cmd_ack <= (state == st_pred_hi);
	end

	// falls together with query_done
	assign query_active = (state == st_active) && !query_done;

	////////////////////////////////////////
	// parameter beat capture
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			st_header:
				record_count <= para_data[CNT_W-1:0];
			st_table:
				table_bits <= para_data[TABLE_W-1:0];
			st_pred_lo:
			begin
				for (int i = 0; i < PREDS_LO; i++)
					preds[i] <= para_data[i*PRED_W +: PRED_W];
			end
			st_pred_hi:
			begin
				for (int i = 0; i < PREDS_HI; i++)
					preds[PREDS_LO+i] <= para_data[i*PRED_W +: PRED_W];
			end
			default:
			begin
				// hold config while idle or active
			end
		endcase
	end

	////////////////////////////////////////
	// record gating
	////////////////////////////////////////

	assign accept = rec_valid && query_active;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			stage_rec <= rec_data;   // same record fans out to all units
	end

endmodule

// File: hdl/query_filter.sv
`timescale 1ns/1ps

module query_filter
	import query_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_pending,
	input  logic [BEAT_W-1:0] para_data,
	output logic              para_rd,
	output logic              cmd_ack,
	input  logic              rec_valid,
	input  record_t           rec_data,
	output logic              query_active,
	output logic              match_valid,
	output logic              match,
	output logic              query_done
);

	pred_set_t           preds;
	truth_table_t        table_bits;
	logic [CNT_W-1:0]    record_count;
	logic                stage_valid;
	record_t             stage_rec;
	logic [NUM_PRED-1:0] hits;
	logic [NUM_PRED-1:0] pred_valid;

	////////////////////////////////////////
	// command load and record gating
	////////////////////////////////////////

	query_controller u_ctrl
	(
		.clk          (clk),
		.rst          (rst),
		.cmd_pending  (cmd_pending),
		.para_data    (para_data),
		.rec_valid    (rec_valid),
		.rec_data     (rec_data),
		.query_done   (query_done),
		.para_rd      (para_rd),
		.cmd_ack      (cmd_ack),
		.query_active (query_active),
		.preds        (preds),
		.table_bits   (table_bits),
		.record_count (record_count),
		.stage_valid  (stage_valid),
		.stage_rec    (stage_rec)
	);

	////////////////////////////////////////
	// predicate stage
	////////////////////////////////////////

	for (genvar g = 0; g < NUM_PRED; g++)
	begin : g_pred
		predicate_unit u_pred
		(
			.clk       (clk),
			.rst       (rst),
			.pred      (preds[g]),
			.in_valid  (stage_valid),
			.rec       (stage_rec),
			.hit       (hits[g]),
			.out_valid (pred_valid[g])
		);
	end

	// all units run in lockstep, unit 0 carries the valid
	match_lookup u_lookup
	(
		.clk          (clk),
		.rst          (rst),
		.in_valid     (pred_valid[0]),
		.hits         (hits),
		.table_bits   (table_bits),
		.record_count (record_count),
		.match_valid  (match_valid),
		.match        (match),
		.query_done   (query_done)
	);

endmodule

// File: tb/query_filter_model.svh
`ifndef QUERY_FILTER_MODEL_SVH
`define QUERY_FILTER_MODEL_SVH

localparam int NUM_Q   = 19;   // 7 opcode, 9 column, 3 random queries
localparam int MAX_REC = 8;
localparam int LATENCY = 3;    // rec_valid to match_valid

// one command as it travels through the four beats
typedef struct packed
{
	logic [CNT_W-1:0] count;
	truth_table_t     tbl;
	pred_set_t        preds;
} query_cfg_t;

// expected output of one pipe slot
typedef struct packed
{
	logic valid;
	logic match;
	logic done;
} pipe_slot_t;

function automatic pred_t make_pred(input logic [7:0] op, input logic [7:0] col,
	input logic [COL_W-1:0] value);
	pred_t p;
	p.value = value;
	p.col   = col;
	p.op    = pred_op_e'(op);
	return p;
endfunction

function automatic logic [BEAT_W-1:0] build_beat(input query_cfg_t cfg, input int idx);
	logic [BEAT_W-1:0] beat;
	beat = '0;
	case (idx)
		0: beat[CNT_W-1:0] = cfg.count;
		1: beat[TABLE_W-1:0] = cfg.tbl;
		2:
		begin
			for (int i = 0; i < PREDS_LO; i++)
				beat[i*PRED_W +: PRED_W] = cfg.preds[i];
		end
		default:
		begin
			for (int i = 0; i < PREDS_HI; i++)
				beat[i*PRED_W +: PRED_W] = cfg.preds[PREDS_LO+i];   // slots restart at bit 0
		end
	endcase
	return beat;
endfunction

// reference compare, unsigned, unknown column or code is false
function automatic logic expect_hit(input pred_t p, input record_t rec);
	logic [COL_W-1:0] v;
	logic             found;
	int               code;
	v     = '0;
	found = 1'b0;
	code  = int'(p.op);
	for (int c = 0; c < NUM_PRED; c++)
	begin
		if (p.col == c)
		begin
			v     = rec[c];
			found = 1'b1;
		end
	end
	if (!found)
		return 1'b0;
	case (code)
		0: return v == p.value;
		1: return v != p.value;
		2: return v < p.value;
		3: return v > p.value;
		4: return v <= p.value;
		5: return v >= p.value;
		default: return 1'b0;
	endcase
endfunction

function automatic logic expect_match(input query_cfg_t cfg, input record_t rec);
	logic [NUM_PRED-1:0] addr;
	for (int i = 0; i < NUM_PRED; i++)
		addr[i] = expect_hit(cfg.preds[i], rec);
	return cfg.tbl[addr];
endfunction

`endif

// File: tb/query_filter_tb.sv
`timescale 1ns/1ps

module query_filter_tb
	import query_pkg::*;
();

`include "query_filter_model.svh"

	logic              clk;
	logic              rst;
	logic              cmd_pending;
	logic [BEAT_W-1:0] para_data;
	logic              para_rd;
	logic              cmd_ack;
	logic              rec_valid;
	record_t           rec_data;
	logic              query_active;
	logic              match_valid;
	logic              match;
	logic              query_done;

	query_cfg_t        cfg_tab[NUM_Q];
	record_t           rec_tab[NUM_Q][MAX_REC];
	logic              exp_tab[NUM_Q][MAX_REC];
	logic [BEAT_W-1:0] beat_q[$];   // parameter FIFO, front drives para_data
	logic              rd_last;
	pipe_slot_t        pipe[LATENCY];
	logic              done_seen;
	int                cycles;
	int                cycle_limit;

	query_filter UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic abort(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [BEAT_W-1:0] actual,
		input logic [BEAT_W-1:0] expected);
		if (actual !== expected)
			abort($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	function automatic record_t random_record(input logic [COL_W-1:0] mask);
		record_t r;
		for (int i = 0; i < NUM_PRED; i++)
			r[i] = $urandom & mask;
		return r;
	endfunction

	////////////////////////////////////////
	// one falling edge, FIFO model and output checks
	////////////////////////////////////////

	task automatic step();
		@(negedge clk);
		cycles++;
		if (cycles > cycle_limit)
			abort($sformatf("timeout, the DUT did not finish within %0d cycles", cycle_limit));
		if (rd_last)
			beat_q.delete(0);   // beat taken at the last rising edge
		para_data = (beat_q.size() != 0) ? beat_q[0] : '0;
		if (para_rd && beat_q.size() == 0)
			abort("para_rd pulsed while the parameter FIFO was empty");
		rd_last = para_rd;
		check_value("match_valid", match_valid, pipe[LATENCY-1].valid);
		if (pipe[LATENCY-1].valid)
			check_value("match", match, pipe[LATENCY-1].match);
		check_value("query_done", query_done, pipe[LATENCY-1].done);
		if (pipe[LATENCY-1].done)
			done_seen = 1'b1;
		for (int i = LATENCY - 1; i > 0; i--)
			pipe[i] = pipe[i-1];
		pipe[0] = '0;
	endtask

	task automatic load_command(input int q);
		int   rd_count;
		logic acked;
		rd_count = 0;
		acked    = 1'b0;
		for (int b = 0; b < NUM_BEATS; b++)
			beat_q.push_back(build_beat(cfg_tab[q], b));
		para_data   = beat_q[0];
		cmd_pending = 1'b1;
		while (!acked)
		begin
			step();
			if (cmd_ack)
			begin
				check_value("para_rd pulse count", rd_count, NUM_BEATS);
				check_value("para_rd", para_rd, 1'b0);
				check_value("query_active", query_active, 1'b1);
				cmd_pending = 1'b0;
				acked       = 1'b1;
			end
			else if (para_rd)
				rd_count++;
			else if (rd_count != 0)
				abort($sformatf("para_rd stopped after %0d beats without cmd_ack", rd_count));
		end
	endtask

	task automatic run_records(input int q);
		int n;
		n = cfg_tab[q].count;
		for (int r = 0; r < n; r++)
		begin
			if (r != 0)
				step();
			check_value("query_active", query_active, 1'b1);
			rec_valid = 1'b1;
			rec_data  = rec_tab[q][r];
			pipe[0]   = {1'b1, exp_tab[q][r], (r == n - 1)};
		end
		done_seen = 1'b0;
		step();
		rec_valid = 1'b0;
		while (!done_seen)
			step();
		check_value("query_active", query_active, 1'b0);
		rec_valid = 1'b1;   // late record, must be dropped
		step();
		rec_valid = 1'b0;
		repeat (LATENCY) step();
		check_value("query_active", query_active, 1'b0);
	endtask

	////////////////////////////////////////
	// query table
	////////////////////////////////////////

	task automatic build_tables();
		query_cfg_t       cfg;
		logic [COL_W-1:0] val;
		int               q;
		int               c;
		q = 0;
		cfg.count = 3;
		for (int n = 0; n < TABLE_W; n++)
			cfg.tbl[n] = n[0];   // match follows predicate 0
		for (int i = 0; i < NUM_PRED; i++)
			cfg.preds[i] = make_pred(8'd0, 8'd1, 32'd0);
		// opcodes 0..5 then an undefined one, column 0 below, equal, above
		for (int k = 0; k < 7; k++)
		begin
			cfg.preds[0] = make_pred((k < 6) ? 8'(k) : 8'h2a, 8'd0, 32'd1000);
			cfg_tab[q] = cfg;
			for (int r = 0; r < 3; r++)
			begin
				rec_tab[q][r]    = random_record('1);
				rec_tab[q][r][0] = 32'd999 + r;
			end
			q++;
		end
		for (int k = 0; k <= NUM_PRED; k++)   // column 8 out of range
		begin
			c   = k % NUM_PRED;
			val = 32'h600d_0000 + k;
			cfg.preds[0] = make_pred(op_eq, 8'(k), val);
			cfg_tab[q] = cfg;
			rec_tab[q][0]    = random_record('1);
			rec_tab[q][0][c] = val;
			rec_tab[q][1]    = random_record('1);
			rec_tab[q][1][c] = val + 1;
			rec_tab[q][2]    = {NUM_PRED{val}};
			rec_tab[q][2][c] = ~val;   // only the selected column differs
			q++;
		end
		// small values so compares land both ways
		for (int k = 0; k < 3; k++)
		begin
			cfg.count = MAX_REC;
			for (int w = 0; w < TABLE_W / 32; w++)
				cfg.tbl[w*32 +: 32] = $urandom;
			for (int i = 0; i < NUM_PRED; i++)
				cfg.preds[i] = make_pred(8'($urandom_range(5, 0)),
					8'($urandom_range(7, 0)), $urandom_range(15, 0));
			cfg_tab[q] = cfg;
			for (int r = 0; r < MAX_REC; r++)
				rec_tab[q][r] = random_record(32'hf);
			for (int i = 0; i < NUM_PRED; i++)
				rec_tab[q][0][cfg.preds[i].col] = cfg.preds[i].value;
			q++;
		end
		for (int i = 0; i < NUM_Q; i++)
			for (int r = 0; r < MAX_REC; r++)
				exp_tab[i][r] = expect_match(cfg_tab[i], rec_tab[i][r]);
	endtask

	initial
	begin
		void'($urandom(32'h5e2b));
		rst         = 1'b0;
		cmd_pending = 1'b0;
		para_data   = '0;
		rec_valid   = 1'b0;
		rec_data    = '0;
		rd_last     = 1'b0;
		done_seen   = 1'b0;
		cycles      = 0;
		for (int i = 0; i < LATENCY; i++)
			pipe[i] = '0;
		build_tables();
		cycle_limit = 0;
		for (int q = 0; q < NUM_Q; q++)
			cycle_limit += 4 * (NUM_BEATS + int'(cfg_tab[q].count) + LATENCY);
		repeat (4) @(negedge clk);
		rst = 1'b1;
		step();
		check_value("para_rd", para_rd, 1'b0);
		check_value("cmd_ack", cmd_ack, 1'b0);
		check_value("query_active", query_active, 1'b0);
		for (int q = 0; q < NUM_Q; q++)
		begin
			load_command(q);
			run_records(q);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+tb
hdl/query_pkg.sv
hdl/predicate_unit.sv
hdl/match_lookup.sv
hdl/query_controller.sv
hdl/query_filter.sv
tb/query_filter_tb.sv
